/* source/probe_pkg.sv */
// stream probe shared definitions
`default_nettype none

package probe_pkg;

   // ============================================================
   // stream widths
   // ============================================================

   // bytes carried by one stream beat
   localparam int data_bytes = 8;

   typedef logic [data_bytes-1:0] keep_t;
   // a full beat has 8 bytes, so 4 bits hold any set-bit count
   typedef logic [3:0]            byte_inc_t;
   typedef logic [49:0]           pkt_count_t;
   typedef logic [55:0]           byte_count_t;

   // ============================================================
   // counting modes and slots
   // ============================================================

   typedef enum logic [1:0] {
      mode_good,
      mode_ovfl,
      mode_errors
   } probe_mode_t;

   // slot 0 holds good, slot 1 overflow and slot 2 errors
   localparam int num_counters = 3;

   // ============================================================
   // AXI4-Lite register map
   // ============================================================

   typedef logic [7:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [1:0]  axil_resp_t;

   localparam axil_resp_t resp_okay   = 2'd0;
   localparam axil_resp_t resp_slverr = 2'd2;

   // each counter slot occupies 16 bytes of address space
   localparam axil_addr_t slot_stride    = 8'h10;
   localparam axil_addr_t reg_pkt_lower  = 8'h00;
   localparam axil_addr_t reg_pkt_upper  = 8'h04;
   localparam axil_addr_t reg_byte_lower = 8'h08;
   localparam axil_addr_t reg_byte_upper = 8'h0c;

   // bit 0 of the control word is the halt flag
   localparam axil_addr_t reg_control    = 8'h30;

endpackage

`default_nettype wire

/* source/stream_counter.sv */
// stream packet and byte counter
`timescale 1ns/1ns
`default_nettype none

module stream_counter
   import probe_pkg::*;
#(
   parameter probe_mode_t mode = mode_good
) (
   input  wire         axi4s_if,
   input  wire         reset,
   input  wire         tvalid,
   input  wire         tready,
   input  wire keep_t  tkeep,
   input  wire         tlast,
   input  wire         tuser,
   input  wire         halt,
   input  wire         clear,
   output pkt_count_t  pkt_count,
   output byte_count_t byte_count
);

   // number of valid bytes in one beat, one per set tkeep bit
   function automatic byte_inc_t count_ones(input keep_t keep);
      byte_inc_t n;
      n = '0;
      for (int i = 0; i < data_bytes; i++) begin
         n = n + byte_inc_t'(keep[i]);
      end
      return n;
   endfunction

   logic        take;
   logic        keep_pkt;
   logic        beat_q;
   logic        last_q;
   logic        keep_pkt_q;
   byte_inc_t   inc_q;
   byte_count_t acc;
   byte_count_t pkt_bytes;

   // ============================================================
   // beat selection
   // ============================================================

   // the overflow slot watches refused beats, the other two watch accepted ones
   always_comb begin
      case (mode)
         mode_ovfl: take = tvalid && !tready;
         default:   take = tvalid && tready;
      endcase
   end

   // decide on the last beat whether the packet is kept or dropped
   // a good packet needs tuser low, an error packet needs it high
   always_comb begin
      case (mode)
         mode_good:   keep_pkt = !tuser;
         mode_errors: keep_pkt = tuser;
         default:     keep_pkt = 1'b1;
      endcase
   end

   // ============================================================
   // stage 1 registers the beat and its byte increment
   // ============================================================

   // while halted no beat enters the pipeline at all
   always_ff @(posedge axi4s_if) begin
      if (reset || clear) begin
         beat_q <= 1'b0;
      end else begin
         beat_q <= take && !halt;
      end
   end

   // payload of the registered beat, only looked at when beat_q is set
   always_ff @(posedge axi4s_if) begin
      last_q     <= tlast;
      keep_pkt_q <= keep_pkt;
      inc_q      <= count_ones(tkeep);
   end

   // ============================================================
   // stage 2 accumulates the packet and commits on tlast
   // ============================================================

   // bytes of the packet so far including the current beat
   assign pkt_bytes = acc + byte_count_t'(inc_q);

   // a clear wipes the partial packet too, so a packet that straddles a
   // clearing read is only partly counted
   always_ff @(posedge axi4s_if) begin
      if (reset || clear) begin
         acc        <= '0;
         pkt_count  <= '0;
         byte_count <= '0;
      end else if (beat_q) begin
         if (last_q) begin
            acc <= '0;
            if (keep_pkt_q) begin
               pkt_count  <= pkt_count + pkt_count_t'(1);
               byte_count <= byte_count + pkt_bytes;
            end
         end else begin
            acc <= pkt_bytes;
         end
      end
   end

   // ============================================================
   // checks
   // ============================================================

   // the only way down for either counter is a clear in the cycle before
   a_no_decrease : assert property (@(posedge axi4s_if) disable iff (reset)
      !$past(clear) |-> (pkt_count >= $past(pkt_count)) &&
                        (byte_count >= $past(byte_count)));

   // the register slave cannot accept two reads back to back
   a_clear_pulse : assert property (@(posedge axi4s_if) disable iff (reset)
      clear |=> !clear);

endmodule

`default_nettype wire

/* source/axil_regs.sv */
// AXI4-Lite counter register slave
`timescale 1ns/1ns
`default_nettype none

module axil_regs
   import probe_pkg::*;
(
   input  wire              axi4s_if,
   input  wire              reset,
   // write address and data channels
   input  wire              awvalid,
   output logic             awready,
   input  wire axil_addr_t  awaddr,
   input  wire              wvalid,
   output logic             wready,
   input  wire axil_data_t  wdata,
   // write response channel
   output logic             bvalid,
   input  wire              bready,
   output axil_resp_t       bresp,
   // read address channel
   input  wire              arvalid,
   output logic             arready,
   input  wire axil_addr_t  araddr,
   // read data channel
   output logic             rvalid,
   input  wire              rready,
   output axil_data_t       rdata,
   output axil_resp_t       rresp,
   // counter values from the three slots
   input  wire pkt_count_t  slot0_pkt_count,
   input  wire byte_count_t slot0_byte_count,
   input  wire pkt_count_t  slot1_pkt_count,
   input  wire byte_count_t slot1_byte_count,
   input  wire pkt_count_t  slot2_pkt_count,
   input  wire byte_count_t slot2_byte_count,
   // controls to the counters
   output logic             halt,
   output logic             clear0,
   output logic             clear1,
   output logic             clear2
);

   typedef enum logic {
      wr_idle,
      wr_resp
   } wr_state_t;

   typedef enum logic {
      rd_idle,
      rd_resp
   } rd_state_t;

   // byte address of one register inside a counter slot
   function automatic axil_addr_t slot_reg(input int slot, input axil_addr_t offset);
      return axil_addr_t'(slot * slot_stride) + offset;
   endfunction

   wr_state_t               wr_state;
   rd_state_t               rd_state;
   logic                    aw_fire;
   logic                    ar_fire;
   logic                    ctrl_hit;
   axil_data_t              rd_word;
   axil_resp_t              rd_code;
   logic [num_counters-1:0] clear_vec;
   pkt_count_t              pkt_counts  [num_counters];
   byte_count_t             byte_counts [num_counters];

   // gather the slot ports so the decode can loop over them
   assign pkt_counts[0]  = slot0_pkt_count;
   assign pkt_counts[1]  = slot1_pkt_count;
   assign pkt_counts[2]  = slot2_pkt_count;
   assign byte_counts[0] = slot0_byte_count;
   assign byte_counts[1] = slot1_byte_count;
   assign byte_counts[2] = slot2_byte_count;

   // ============================================================
   // write path
   // ============================================================

   // address and data are taken together in one cycle, and only while no
   // response is waiting for bready
   assign awready  = (wr_state == wr_idle) && awvalid && wvalid;
   assign wready   = awready;
   assign aw_fire  = awready;
   assign bvalid   = (wr_state == wr_resp);
   assign ctrl_hit = (awaddr == reg_control);

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         wr_state <= wr_idle;
         halt     <= 1'b0;
      end else begin
         case (wr_state)
            wr_idle: begin
               if (aw_fire) begin
                  wr_state <= wr_resp;
                  if (ctrl_hit) begin
                     halt <= wdata[0];
                  end
               end
            end
            default: begin
               if (bready) begin
                  wr_state <= wr_idle;
               end
            end
         endcase
      end
   end

   // only the control word is writable, the counters are read only
   always_ff @(posedge axi4s_if) begin
      if (aw_fire) begin
         bresp <= ctrl_hit ? resp_okay : resp_slverr;
      end
   end

   // ============================================================
   // read path
   // ============================================================

   assign arready = (rd_state == rd_idle);
   assign ar_fire = arvalid && arready;
   assign rvalid  = (rd_state == rd_resp);

   // readback mux, anything not matched stays at zero with an error response
   always_comb begin
      rd_word = '0;
      rd_code = resp_slverr;
      if (araddr == reg_control) begin
         rd_word = axil_data_t'(halt);
         rd_code = resp_okay;
      end
      for (int i = 0; i < num_counters; i++) begin
         if (araddr == slot_reg(i, reg_pkt_lower)) begin
            rd_word = axil_data_t'(pkt_counts[i]);
            rd_code = resp_okay;
         end
         // upper words come out zero extended
         if (araddr == slot_reg(i, reg_pkt_upper)) begin
            rd_word = axil_data_t'(pkt_counts[i] >> 32);
            rd_code = resp_okay;
         end
         if (araddr == slot_reg(i, reg_byte_lower)) begin
            rd_word = axil_data_t'(byte_counts[i]);
            rd_code = resp_okay;
         end
         if (araddr == slot_reg(i, reg_byte_upper)) begin
            rd_word = axil_data_t'(byte_counts[i] >> 32);
            rd_code = resp_okay;
         end
      end
   end

   // reading the byte lower word clears that slot's pair in the same cycle
   // the word is captured, so the read returns the value before the clear
   always_comb begin
      for (int i = 0; i < num_counters; i++) begin
         clear_vec[i] = ar_fire && (araddr == slot_reg(i, reg_byte_lower));
      end
   end

   assign clear0 = clear_vec[0];
   assign clear1 = clear_vec[1];
   assign clear2 = clear_vec[2];

   always_ff @(posedge axi4s_if) begin
      if (reset) begin
         rd_state <= rd_idle;
      end else if (ar_fire) begin
         rd_state <= rd_resp;
      end else if (rvalid && rready) begin
         rd_state <= rd_idle;
      end
   end

   // read data is held from acceptance until rready
   always_ff @(posedge axi4s_if) begin
      if (ar_fire) begin
         rdata <= rd_word;
         rresp <= rd_code;
      end
   end

   // ============================================================
   // checks
   // ============================================================

   a_bvalid_hold : assert property (@(posedge axi4s_if) disable iff (reset)
      bvalid && !bready |=> bvalid);

   a_rvalid_hold : assert property (@(posedge axi4s_if) disable iff (reset)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

/* source/stream_probe_top.sv */
// stream probe top level
`timescale 1ns/1ns
`default_nettype none

module stream_probe_top
   import probe_pkg::*;
(
   input  wire             axi4s_if,
   input  wire             reset,
   // observed stream, never driven by the probe
   input  wire             tvalid,
   input  wire             tready,
   input  wire keep_t      tkeep,
   input  wire             tlast,
   input  wire             tuser,
   // AXI4-Lite register slave
   input  wire             awvalid,
   output logic            awready,
   input  wire axil_addr_t awaddr,
   input  wire             wvalid,
   output logic            wready,
   input  wire axil_data_t wdata,
   output logic            bvalid,
   input  wire             bready,
   output axil_resp_t      bresp,
   input  wire             arvalid,
   output logic            arready,
   input  wire axil_addr_t araddr,
   output logic            rvalid,
   input  wire             rready,
   output axil_data_t      rdata,
   output axil_resp_t      rresp
);

   logic        halt;
   logic        clear_good;
   logic        clear_ovfl;
   logic        clear_errors;
   pkt_count_t  good_pkts;
   byte_count_t good_bytes;
   pkt_count_t  ovfl_pkts;
   byte_count_t ovfl_bytes;
   pkt_count_t  errors_pkts;
   byte_count_t errors_bytes;

   // slot order in the register map is good, overflow, errors
   axil_regs regs_i (
      .axi4s_if         (axi4s_if),
      .reset            (reset),
      .awvalid          (awvalid),
      .awready          (awready),
      .awaddr           (awaddr),
      .wvalid           (wvalid),
      .wready           (wready),
      .wdata            (wdata),
      .bvalid           (bvalid),
      .bready           (bready),
      .bresp            (bresp),
      .arvalid          (arvalid),
      .arready          (arready),
      .araddr           (araddr),
      .rvalid           (rvalid),
      .rready           (rready),
      .rdata            (rdata),
      .rresp            (rresp),
      .slot0_pkt_count  (good_pkts),
      .slot0_byte_count (good_bytes),
      .slot1_pkt_count  (ovfl_pkts),
      .slot1_byte_count (ovfl_bytes),
      .slot2_pkt_count  (errors_pkts),
      .slot2_byte_count (errors_bytes),
      .halt             (halt),
      .clear0           (clear_good),
      .clear1           (clear_ovfl),
      .clear2           (clear_errors)
   );

   stream_counter #(.mode(mode_good)) cnt_good_i (
      .axi4s_if   (axi4s_if),
      .reset      (reset),
      .tvalid     (tvalid),
      .tready     (tready),
      .tkeep      (tkeep),
      .tlast      (tlast),
      .tuser      (tuser),
      .halt       (halt),
      .clear      (clear_good),
      .pkt_count  (good_pkts),
      .byte_count (good_bytes)
   );

   stream_counter #(.mode(mode_ovfl)) cnt_ovfl_i (
      .axi4s_if   (axi4s_if),
      .reset      (reset),
      .tvalid     (tvalid),
      .tready     (tready),
      .tkeep      (tkeep),
      .tlast      (tlast),
      .tuser      (tuser),
      .halt       (halt),
      .clear      (clear_ovfl),
      .pkt_count  (ovfl_pkts),
      .byte_count (ovfl_bytes)
   );

   stream_counter #(.mode(mode_errors)) cnt_errors_i (
      .axi4s_if   (axi4s_if),
      .reset      (reset),
      .tvalid     (tvalid),
      .tready     (tready),
      .tkeep      (tkeep),
      .tlast      (tlast),
      .tuser      (tuser),
      .halt       (halt),
      .clear      (clear_errors),
      .pkt_count  (errors_pkts),
      .byte_count (errors_bytes)
   );

endmodule

`default_nettype wire

/* testbench/stream_probe_tb.sv */
// stream probe testbench
`timescale 1ns/1ns
`default_nettype none

module stream_probe_tb
   import probe_pkg::*;
;

   // upper bounds on traffic and register accesses, used by the watchdog
   localparam int num_packets    = 90;
   localparam int num_accesses   = 90;
   localparam int timeout_cycles = num_packets * 8 + num_accesses * 10 + 200;

   logic axi4s_if;
   logic reset;
   logic tvalid;
   logic tready;
   keep_t tkeep;
   logic tlast;
   logic tuser;
   logic awvalid;
   logic awready;
   axil_addr_t awaddr;
   logic wvalid;
   logic wready;
   axil_data_t wdata;
   logic bvalid;
   logic bready;
   axil_resp_t bresp;
   logic arvalid;
   logic arready;
   axil_addr_t araddr;
   logic rvalid;
   logic rready;
   axil_data_t rdata;
   axil_resp_t rresp;

   integer seed;
   logic halt_on;
   // expected committed counts and open packet bytes, slot 0 good, 1 ovfl, 2 errors
   logic [63:0] exp_pkts [3];
   logic [63:0] exp_bytes [3];
   logic [63:0] open_bytes [3];

   stream_probe_top stream_probe_top_i (.*);

   initial begin
      axi4s_if = 1'b0;
      forever #20 axi4s_if = ~axi4s_if;
   end

   initial begin
      repeat (timeout_cycles) @(posedge axi4s_if);
      $display("watchdog expired before all tests completed");
      $display("Simulation FAILED");
      $fatal(1, "run timed out");
   end

   // ============================================================
   // reference model
   // ============================================================

   // each set keep bit stands for one valid byte
   function automatic int keep_bytes(input keep_t keep);
      int n;
      n = 0;
      for (int b = 0; b < data_bytes; b++) begin
         if (keep[b]) n++;
      end
      return n;
   endfunction

   function automatic void model_beat(input keep_t keep, input logic last, input logic user,
                                      input logic ready);
      if (halt_on) return;
      if (ready) begin
         // accepted beats feed both the good and the errors slot
         open_bytes[0] += keep_bytes(keep);
         open_bytes[2] += keep_bytes(keep);
         if (last) begin
            if (!user) begin
               exp_pkts[0]++;
               exp_bytes[0] += open_bytes[0];
            end else begin
               exp_pkts[2]++;
               exp_bytes[2] += open_bytes[2];
            end
            open_bytes[0] = 0;
            open_bytes[2] = 0;
         end
      end else begin
         open_bytes[1] += keep_bytes(keep);
         if (last) begin
            exp_pkts[1]++;
            exp_bytes[1] += open_bytes[1];
            open_bytes[1] = 0;
         end
      end
   endfunction

   // ============================================================
   // stream stimulus
   // ============================================================

   task automatic idle_cycles(input int n);
      tvalid = 1'b0;
      repeat (n) begin
         @(posedge axi4s_if);
         #5;
      end
   endtask

   task automatic drive_beat(input keep_t keep, input logic last, input logic user,
                             input logic ready);
      tvalid = 1'b1;
      tready = ready;
      tkeep  = keep;
      tlast  = last;
      tuser  = user;
      model_beat(keep, last, user, ready);
      @(posedge axi4s_if);
      #5;
   endtask

   // a refused beat is offered again with tready high on the next cycle
   task automatic send_packets(input int count, input bit with_errors, input bit with_gaps);
      int len;
      keep_t keep;
      logic last;
      logic user;
      for (int p = 0; p < count; p++) begin
         len = 1 + ($unsigned($random(seed)) % 6);
         for (int b = 0; b < len; b++) begin
            keep = keep_t'($random(seed));
            last = (b == len - 1);
            user = with_errors && last && ($random(seed) & 1);
            if (with_gaps && (($random(seed) & 3) == 0)) drive_beat(keep, last, user, 1'b0);
            drive_beat(keep, last, user, 1'b1);
         end
         idle_cycles($unsigned($random(seed)) % 2);
      end
      // let the last packet reach the committed counters
      idle_cycles(4);
   endtask

   // ============================================================
   // AXI4-Lite master and checks
   // ============================================================

   task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
      arvalid = 1'b1;
      araddr  = addr;
      rready  = 1'b1;
      @(negedge axi4s_if);
      while (!arready) @(negedge axi4s_if);
      @(posedge axi4s_if);
      #5;
      arvalid = 1'b0;
      @(negedge axi4s_if);
      while (!rvalid) @(negedge axi4s_if);
      data = rdata;
      resp = rresp;
      @(posedge axi4s_if);
      #5;
      rready = 1'b0;
   endtask

   task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                            output axil_resp_t resp);
      awvalid = 1'b1;
      awaddr  = addr;
      wvalid  = 1'b1;
      wdata   = data;
      bready  = 1'b1;
      @(negedge axi4s_if);
      while (!awready) @(negedge axi4s_if);
      @(posedge axi4s_if);
      #5;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      @(negedge axi4s_if);
      while (!bvalid) @(negedge axi4s_if);
      resp = bresp;
      @(posedge axi4s_if);
      #5;
      bready = 1'b0;
   endtask

   task automatic compare(input string test, input logic [63:0] expected,
                          input logic [63:0] actual);
      assert (actual === expected) else begin
         $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   task automatic check_read(input string test, input axil_addr_t addr,
                             input axil_data_t exp_data, input axil_resp_t exp_resp);
      axil_data_t data;
      axil_resp_t resp;
      read_reg(addr, data, resp);
      compare({test, " rdata"}, exp_data, data);
      compare({test, " rresp"}, exp_resp, resp);
   endtask

   task automatic check_write(input string test, input axil_addr_t addr,
                              input axil_data_t data, input axil_resp_t exp_resp);
      axil_resp_t resp;
      write_reg(addr, data, resp);
      compare({test, " bresp"}, exp_resp, resp);
   endtask

   // the byte lower word goes last, since reading it clears the slot
   task automatic check_slot(input string test, input int slot);
      axil_addr_t base;
      base = axil_addr_t'(slot * 16);
      check_read($sformatf("%s slot%0d pkt_lower", test, slot), base + reg_pkt_lower,
                 exp_pkts[slot][31:0], resp_okay);
      check_read($sformatf("%s slot%0d pkt_upper", test, slot), base + reg_pkt_upper,
                 exp_pkts[slot][63:32], resp_okay);
      check_read($sformatf("%s slot%0d byte_upper", test, slot), base + reg_byte_upper,
                 exp_bytes[slot][63:32], resp_okay);
      check_read($sformatf("%s slot%0d byte_lower", test, slot), base + reg_byte_lower,
                 exp_bytes[slot][31:0], resp_okay);
      exp_pkts[slot]   = 0;
      exp_bytes[slot]  = 0;
      open_bytes[slot] = 0;
   endtask

   task automatic check_all(input string test);
      for (int s = 0; s < num_counters; s++) check_slot(test, s);
   endtask

   // ============================================================
   // test sequence
   // ============================================================

   initial begin
      seed    = 66343;
      halt_on = 1'b0;
      for (int s = 0; s < 3; s++) begin
         exp_pkts[s]   = 0;
         exp_bytes[s]  = 0;
         open_bytes[s] = 0;
      end
      reset   = 1'b1;
      tvalid  = 1'b0;
      tready  = 1'b1;
      tkeep   = '0;
      tlast   = 1'b0;
      tuser   = 1'b0;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      repeat (10) @(posedge axi4s_if);
      #5;
      reset = 1'b0;

      check_all("after_reset");
      check_read("after_reset control", reg_control, 0, resp_okay);

      send_packets(20, 1'b0, 1'b0);
      check_all("good_only");

      send_packets(30, 1'b1, 1'b1);
      check_all("errors_ovfl");

      // traffic during halt must leave every counter alone
      check_write("halt set", reg_control, 1, resp_okay);
      halt_on = 1'b1;
      check_read("halt control", reg_control, 1, resp_okay);
      send_packets(10, 1'b1, 1'b1);
      check_write("halt release", reg_control, 0, resp_okay);
      halt_on = 1'b0;
      send_packets(10, 1'b1, 1'b1);
      check_all("halt");

      send_packets(10, 1'b1, 1'b1);
      check_slot("clear_first", 0);
      check_slot("clear_second", 0);
      check_slot("clear_others", 1);
      check_slot("clear_others", 2);

      send_packets(10, 1'b1, 1'b1);
      check_read("unmapped 0x34", 8'h34, 0, resp_slverr);
      check_read("unmapped 0x40", 8'h40, 0, resp_slverr);
      check_read("unmapped 0xfc", 8'hfc, 0, resp_slverr);
      check_write("counter write slot0", 8'h00, 32'h1234, resp_slverr);
      check_write("counter write slot1", 8'h18, 32'hffff, resp_slverr);
      // a rejected write with bit 0 set must not reach the halt flag
      check_read("unmapped control", reg_control, 0, resp_okay);
      check_all("unmapped");

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
source/probe_pkg.sv
source/stream_counter.sv
source/axil_regs.sv
source/stream_probe_top.sv
testbench/stream_probe_tb.sv

/* Bender.yml */
package:
  name: stream_probe

dependencies: {}

sources:
  # package first, then the counters, the register slave and the top level
  - source/probe_pkg.sv
  - source/stream_counter.sv
  - source/axil_regs.sv
  - source/stream_probe_top.sv

  # simulation only
  - target: test
    files:
      - testbench/stream_probe_tb.sv
